/* compile.f */
+incdir+.
dma_pkg.sv
dma_fifo.sv
dma_apb_regs.sv
dma_read_engine.sv
dma_write_engine.sv
dma_top.sv
tb_dma.sv

/* dma_apb_regs.sv */
// DMA register block with repeat timer and four-phase command issue
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_apb_regs
	import dma_pkg::*;
(
	input  logic     clk_apb,
	input  logic     rstnn_apb,
	input  apb_req_t i_apb,
	output apb_rsp_t o_apb,
	input  logic     i_tick_1us,
	output dma_cmd_t o_cmd,
	output logic     o_cmd_req,
	input  logic     i_cmd_ack,
	output logic     o_irq
);

typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_DROP, ST_WAIT} state_t;

state_t             state;
logic [`DMA_DW-1:0] src_reg;
logic [`DMA_DW-1:0] dst_reg;
logic [`DMA_DW-1:0] size_reg;
logic [`DMA_DW-1:0] stride_reg;
logic [`DMA_DW-1:0] period_reg;
logic [`DMA_DW-1:0] period_cnt;
logic [`DMA_DW-1:0] run_cnt;
logic [`DMA_DW-1:0] prdata;
logic [7:0]         offset;
logic               repeat_en;
logic               irq;
logic               busy;
logic               start_pend;
logic               addr_ok;
logic               wr_en;
logic               start_wr;
logic               done;

assign offset   = i_apb.paddr[7:0];
assign wr_en    = i_apb.psel & i_apb.penable & i_apb.pwrite & addr_ok;
assign start_wr = wr_en & (offset == `DMA_REG_CTRL) & i_apb.pwdata[0];
assign done     = (state == ST_REQ) & i_cmd_ack;
assign busy     = (state == ST_REQ);

// ************************************************
// APB read decode, no wait states
// ************************************************
always_comb
begin
	addr_ok = 1'b0;
	prdata  = '0;
	if (i_apb.paddr[`DMA_AW-1:8] == '0)
	begin
		addr_ok = 1'b1;
		case (offset)
			`DMA_REG_CTRL:   prdata[1] = repeat_en;
			`DMA_REG_SRC:    prdata = src_reg;
			`DMA_REG_DST:    prdata = dst_reg;
			`DMA_REG_SIZE:   prdata = size_reg;
			`DMA_REG_STRIDE: prdata = stride_reg;
			`DMA_REG_PERIOD: prdata = period_reg;
			`DMA_REG_STATUS:
			begin
				prdata[0] = busy;
				prdata[1] = irq;
			end
			`DMA_REG_RUNS:   prdata = run_cnt;
			default:         addr_ok = 1'b0;
		endcase
	end
end

assign o_apb.prdata  = prdata;
assign o_apb.pready  = 1'b1;
assign o_apb.pslverr = i_apb.psel & ~addr_ok;

always_ff @(posedge clk_apb or negedge rstnn_apb)
begin
	if (!rstnn_apb)
	begin
		src_reg    <= '0;
		dst_reg    <= '0;
		size_reg   <= '0;
		stride_reg <= '0;
		period_reg <= '0;
		repeat_en  <= 1'b0;
		irq        <= 1'b0;
		run_cnt    <= '0;
	end
	else
	begin
		if (wr_en)
		begin
			case (offset)
				`DMA_REG_CTRL:   repeat_en <= i_apb.pwdata[1];
				`DMA_REG_SRC:    src_reg <= i_apb.pwdata;
				`DMA_REG_DST:    dst_reg <= i_apb.pwdata;
				`DMA_REG_SIZE:   size_reg <= i_apb.pwdata;
				`DMA_REG_STRIDE: stride_reg <= i_apb.pwdata;
				`DMA_REG_PERIOD: period_reg <= i_apb.pwdata;
				`DMA_REG_STATUS:
					if (i_apb.pwdata[1])
						irq <= 1'b0;
				default: ;
			endcase
		end
		// Completion wins over a clear in the same cycle
		if (done)
		begin
			irq     <= 1'b1;
			run_cnt <= run_cnt + 1'b1;
		end
	end
end

// ************************************************
// Control FSM and repeat period
// ************************************************
always_ff @(posedge clk_apb or negedge rstnn_apb)
begin
	if (!rstnn_apb)
	begin
		state      <= ST_IDLE;
		start_pend <= 1'b0;
		period_cnt <= '0;
	end
	else
	begin
		case (state)
			ST_IDLE:
				if (start_wr)
					state <= ST_REQ;
			ST_REQ:
				if (i_cmd_ack)
					state <= ST_DROP;
			ST_DROP:
			begin
				// Start seen while the ack is still high
				if (start_wr)
					start_pend <= 1'b1;
				if (!i_cmd_ack)
				begin
					start_pend <= 1'b0;
					period_cnt <= '0;
					if (start_pend || start_wr)
						state <= ST_REQ;
					else if (repeat_en)
						state <= ST_WAIT;
					else
						state <= ST_IDLE;
				end
			end
			ST_WAIT:
				if (!repeat_en)
					state <= ST_IDLE;
				else if (i_tick_1us)
				begin
					if (period_cnt == period_reg)
						state <= ST_REQ;
					else
						period_cnt <= period_cnt + 1'b1;
				end
			default:
				state <= ST_IDLE;
		endcase
	end
end

// Command follows the registers until req is raised, then holds
always_ff @(posedge clk_apb)
begin
	if (state != ST_REQ)
	begin
		o_cmd.src        <= src_reg[`DMA_AW-1:0];
		o_cmd.dst        <= dst_reg[`DMA_AW-1:0];
		o_cmd.words      <= size_reg[`DMA_CNT_W-1:0];
		o_cmd.lines      <= size_reg[2*`DMA_CNT_W-1:`DMA_CNT_W];
		o_cmd.src_stride <= stride_reg[`DMA_CNT_W-1:0];
		o_cmd.dst_stride <= stride_reg[2*`DMA_CNT_W-1:`DMA_CNT_W];
	end
end

assign o_cmd_req = (state == ST_REQ);
assign o_irq     = irq;

endmodule

/* dma_cfg.svh */
// DMA configuration macros for widths, buffer depth and the register map
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Word address and data widths
`define DMA_AW 32
`define DMA_DW 32

// Line size, line count and stride fields
`define DMA_CNT_W 16

// Words buffered between the read and write ports
`define DMA_FIFO_DEPTH 4

// ************************************************
// Register offsets
// ************************************************
`define DMA_REG_CTRL   8'h00
`define DMA_REG_SRC    8'h04
`define DMA_REG_DST    8'h08
`define DMA_REG_SIZE   8'h0C
`define DMA_REG_STRIDE 8'h10
`define DMA_REG_PERIOD 8'h14
`define DMA_REG_STATUS 8'h18
`define DMA_REG_RUNS   8'h1C

`endif

/* dma_fifo.sv */
// Word buffer between the DMA read engine and write engine
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_fifo
(
	input  logic               clk_apb,
	input  logic               rstnn_apb,
	input  logic               i_push,
	input  logic [`DMA_DW-1:0] i_data,
	output logic               o_full,
	input  logic               i_pop,
	output logic [`DMA_DW-1:0] o_data,
	output logic               o_empty
);

localparam int DEPTH = `DMA_FIFO_DEPTH;
localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int OCC_W = $clog2(DEPTH + 1);

logic [`DMA_DW-1:0] mem [DEPTH];
logic [PTR_W-1:0]   wr_ptr;
logic [PTR_W-1:0]   rd_ptr;
logic [OCC_W-1:0]   count;
logic               do_push;
logic               do_pop;

function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
	return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
endfunction

assign o_full  = (count == OCC_W'(DEPTH));
assign o_empty = (count == '0);
assign do_push = i_push & ~o_full;
assign do_pop  = i_pop & ~o_empty;

// Head word is visible while not empty
assign o_data = mem[rd_ptr];

always_ff @(posedge clk_apb or negedge rstnn_apb)
begin
	if (!rstnn_apb)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end
	else
	begin
		if (do_push)
			wr_ptr <= next_ptr(wr_ptr);
		if (do_pop)
			rd_ptr <= next_ptr(rd_ptr);
		count <= count + OCC_W'(do_push) - OCC_W'(do_pop);
	end
end

always_ff @(posedge clk_apb)
begin
	if (do_push)
		mem[wr_ptr] <= i_data;
end

endmodule

/* dma_pkg.sv */
// Shared types for the DMA command, the memory ports and the APB port
`include "dma_cfg.svh"

package dma_pkg;

	// One transfer as programmed by software
	typedef struct packed
	{
		logic [`DMA_AW-1:0]    src;
		logic [`DMA_AW-1:0]    dst;
		logic [`DMA_CNT_W-1:0] words;
		logic [`DMA_CNT_W-1:0] lines;
		logic [`DMA_CNT_W-1:0] src_stride;
		logic [`DMA_CNT_W-1:0] dst_stride;
	} dma_cmd_t;

	// Single-beat memory request, data unused on reads
	typedef struct packed
	{
		logic               valid;
		logic [`DMA_AW-1:0] addr;
		logic [`DMA_DW-1:0] data;
	} mem_req_t;

	typedef struct packed
	{
		logic               valid;
		logic [`DMA_DW-1:0] data;
	} mem_rsp_t;

	// ************************************************
	// APB slave port
	// ************************************************
	typedef struct packed
	{
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [`DMA_AW-1:0] paddr;
		logic [`DMA_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed
	{
		logic [`DMA_DW-1:0] prdata;
		logic               pready;
		logic               pslverr;
	} apb_rsp_t;

endpackage

/* dma_read_engine.sv */
// DMA read engine, walks source lines and issues reads within buffer credits
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_read_engine
	import dma_pkg::*;
(
	input  logic               clk_apb,
	input  logic               rstnn_apb,
	input  dma_cmd_t           i_cmd,
	input  logic               i_cmd_req,
	output mem_req_t           o_rd_req,
	input  logic               i_rd_ready,
	input  mem_rsp_t           i_rd_rsp,
	output logic               o_push,
	output logic [`DMA_DW-1:0] o_push_data,
	input  logic               i_pop
);

localparam int CREDIT_W = $clog2(`DMA_FIFO_DEPTH + 1);

logic                  req_q;
logic                  busy;
logic                  start;
logic                  issue;
logic                  last_word;
logic                  last_line;
logic [CREDIT_W-1:0]   credit;
logic [`DMA_AW-1:0]    line_base;
logic [`DMA_CNT_W-1:0] word_cnt;
logic [`DMA_CNT_W-1:0] line_cnt;
logic [`DMA_CNT_W-1:0] words_q;
logic [`DMA_CNT_W-1:0] lines_q;
logic [`DMA_CNT_W-1:0] stride_q;

// Latch only on a fresh req, not the tail of one already served
assign start     = i_cmd_req & ~req_q & ~busy;
assign last_word = (word_cnt == words_q - 1'b1);
assign last_line = (line_cnt == lines_q - 1'b1);

// One credit per read in flight or word still buffered
assign o_rd_req.valid = busy & (credit < CREDIT_W'(`DMA_FIFO_DEPTH));
assign o_rd_req.addr  = line_base + `DMA_AW'(word_cnt);
assign o_rd_req.data  = '0;
assign issue          = o_rd_req.valid & i_rd_ready;

always_ff @(posedge clk_apb or negedge rstnn_apb)
begin
	if (!rstnn_apb)
	begin
		req_q    <= 1'b0;
		busy     <= 1'b0;
		word_cnt <= '0;
		line_cnt <= '0;
		credit   <= '0;
	end
	else
	begin
		req_q <= i_cmd_req;
		if (start)
		begin
			word_cnt <= '0;
			line_cnt <= '0;
			busy     <= (i_cmd.words != '0) && (i_cmd.lines != '0);
		end
		else if (issue)
		begin
			if (last_word)
			begin
				word_cnt <= '0;
				line_cnt <= line_cnt + 1'b1;
				if (last_line)
					busy <= 1'b0;
			end
			else
				word_cnt <= word_cnt + 1'b1;
		end
		credit <= credit + CREDIT_W'(issue) - CREDIT_W'(i_pop);
	end
end

always_ff @(posedge clk_apb)
begin
	if (start)
	begin
		words_q   <= i_cmd.words;
		lines_q   <= i_cmd.lines;
		stride_q  <= i_cmd.src_stride;
		line_base <= i_cmd.src;
	end
	else if (issue && last_word)
		line_base <= line_base + `DMA_AW'(stride_q);  // next source line
end

// Responses arrive in order and always find a free slot
assign o_push      = i_rd_rsp.valid;
assign o_push_data = i_rd_rsp.data;

endmodule

/* dma_top.sv */
// DMA top level joining the register block, both engines and the buffer
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_top
	import dma_pkg::*;
(
	input  logic     clk_apb,
	input  logic     rstnn_apb,
	input  apb_req_t i_apb,
	output apb_rsp_t o_apb,
	input  logic     i_tick_1us,
	output mem_req_t o_rd_req,
	input  logic     i_rd_ready,
	input  mem_rsp_t i_rd_rsp,
	output mem_req_t o_wr_req,
	input  logic     i_wr_ready,
	output logic     o_irq
);

dma_cmd_t           cmd;
logic               cmd_req;
logic               cmd_ack;
logic               push;
logic [`DMA_DW-1:0] push_data;
logic               pop;
logic [`DMA_DW-1:0] fifo_data;
logic               fifo_empty;

// ************************************************
// Control
// ************************************************
dma_apb_regs u_regs
(
	.clk_apb    (clk_apb),
	.rstnn_apb  (rstnn_apb),
	.i_apb      (i_apb),
	.o_apb      (o_apb),
	.i_tick_1us (i_tick_1us),
	.o_cmd      (cmd),
	.o_cmd_req  (cmd_req),
	.i_cmd_ack  (cmd_ack),
	.o_irq      (o_irq)
);

// ************************************************
// Datapath
// ************************************************
dma_read_engine u_rd
(
	.clk_apb     (clk_apb),
	.rstnn_apb   (rstnn_apb),
	.i_cmd       (cmd),
	.i_cmd_req   (cmd_req),
	.o_rd_req    (o_rd_req),
	.i_rd_ready  (i_rd_ready),
	.i_rd_rsp    (i_rd_rsp),
	.o_push      (push),
	.o_push_data (push_data),
	.i_pop       (pop)
);

// Full is never hit, the read credits reserve a slot per read
dma_fifo u_fifo
(
	.clk_apb   (clk_apb),
	.rstnn_apb (rstnn_apb),
	.i_push    (push),
	.i_data    (push_data),
	.o_full    (),
	.i_pop     (pop),
	.o_data    (fifo_data),
	.o_empty   (fifo_empty)
);

dma_write_engine u_wr
(
	.clk_apb    (clk_apb),
	.rstnn_apb  (rstnn_apb),
	.i_cmd      (cmd),
	.i_cmd_req  (cmd_req),
	.o_cmd_ack  (cmd_ack),
	.i_empty    (fifo_empty),
	.i_data     (fifo_data),
	.o_pop      (pop),
	.o_wr_req   (o_wr_req),
	.i_wr_ready (i_wr_ready)
);

endmodule

/* dma_write_engine.sv */
// DMA write engine, drains the buffer to destination lines and acks the command
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_write_engine
	import dma_pkg::*;
(
	input  logic               clk_apb,
	input  logic               rstnn_apb,
	input  dma_cmd_t           i_cmd,
	input  logic               i_cmd_req,
	output logic               o_cmd_ack,
	input  logic               i_empty,
	input  logic [`DMA_DW-1:0] i_data,
	output logic               o_pop,
	output mem_req_t           o_wr_req,
	input  logic               i_wr_ready
);

typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_ACK} state_t;

state_t                state;
logic                  accept;
logic                  last_word;
logic                  last_line;
logic [`DMA_AW-1:0]    line_base;
logic [`DMA_CNT_W-1:0] word_cnt;
logic [`DMA_CNT_W-1:0] line_cnt;
logic [`DMA_CNT_W-1:0] words_q;
logic [`DMA_CNT_W-1:0] lines_q;
logic [`DMA_CNT_W-1:0] stride_q;

assign last_word = (word_cnt == words_q - 1'b1);
assign last_line = (line_cnt == lines_q - 1'b1);

// Head word stays put until the write is accepted
assign o_wr_req.valid = (state == ST_RUN) & ~i_empty;
assign o_wr_req.addr  = line_base + `DMA_AW'(word_cnt);
assign o_wr_req.data  = i_data;
assign accept         = o_wr_req.valid & i_wr_ready;
assign o_pop          = accept;
assign o_cmd_ack      = (state == ST_ACK);

always_ff @(posedge clk_apb or negedge rstnn_apb)
begin
	if (!rstnn_apb)
	begin
		state    <= ST_IDLE;
		word_cnt <= '0;
		line_cnt <= '0;
	end
	else
	begin
		case (state)
			ST_IDLE:
				if (i_cmd_req)
				begin
					word_cnt <= '0;
					line_cnt <= '0;
					// Empty transfer acks straight away
					if ((i_cmd.words == '0) || (i_cmd.lines == '0))
						state <= ST_ACK;
					else
						state <= ST_RUN;
				end
			ST_RUN:
				if (accept)
				begin
					if (last_word)
					begin
						word_cnt <= '0;
						line_cnt <= line_cnt + 1'b1;
						if (last_line)
							state <= ST_ACK;
					end
					else
						word_cnt <= word_cnt + 1'b1;
				end
			ST_ACK:
				if (!i_cmd_req)
					state <= ST_IDLE;
			default:
				state <= ST_IDLE;
		endcase
	end
end

always_ff @(posedge clk_apb)
begin
	if ((state == ST_IDLE) && i_cmd_req)
	begin
		words_q   <= i_cmd.words;
		lines_q   <= i_cmd.lines;
		stride_q  <= i_cmd.dst_stride;
		line_base <= i_cmd.dst;
	end
	else if (accept && last_word)
		line_base <= line_base + `DMA_AW'(stride_q);
end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_dma -o sim_dma
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_dma > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0

/* tb_dma.sv */
// DMA testbench with APB access, memory models and table-driven transfer tests
`timescale 1ns/10ps
`include "dma_cfg.svh"

module tb_dma
	import dma_pkg::*;
();

localparam int NUM_TESTS = 5;
localparam int TIMEOUT   = 2000;

typedef struct packed
{
	logic [31:0] src;
	logic [31:0] dst;
	logic [15:0] words;
	logic [15:0] lines;
	logic [15:0] src_stride;
	logic [15:0] dst_stride;
	logic        full_ready;
	logic        rpt;
	logic        poke;
	logic [7:0]  period;
} row_t;

logic        clk_apb;
logic        rstnn_apb;
apb_req_t    apb_req;
apb_rsp_t    apb_rsp;
logic        tick_1us;
mem_req_t    rd_req;
logic        rd_ready;
mem_rsp_t    rd_rsp;
mem_req_t    wr_req;
logic        wr_ready;
logic        irq;

logic [31:0] src_mem [256];
logic [31:0] dst_mem [256];
logic [31:0] exp_mem [256];
logic [7:0]  rd_addr_q [$];
int          rd_due_q [$];
int          rd_count;
int          wr_count;
int          cyc;
logic        full_ready;
logic        tick_en;
logic [31:0] lfsr;
row_t        tests [NUM_TESTS];
string       names [NUM_TESTS];

dma_top u_dut
(
	.clk_apb    (clk_apb),
	.rstnn_apb  (rstnn_apb),
	.i_apb      (apb_req),
	.o_apb      (apb_rsp),
	.i_tick_1us (tick_1us),
	.o_rd_req   (rd_req),
	.i_rd_ready (rd_ready),
	.i_rd_rsp   (rd_rsp),
	.o_wr_req   (wr_req),
	.i_wr_ready (wr_ready),
	.o_irq      (irq)
);

initial
begin
	clk_apb = 1'b0;
	forever
		#10 clk_apb = ~clk_apb;
end

// Galois LFSR, one step per bit taken
function automatic logic lfsr_bit();
	lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
	return lfsr[0];
endfunction

// **************************************************
// Failure reporting and checks
// **************************************************
task automatic abort_run(input string why);
	$display("%s", why);
	$display("TEST FAILED");
	$fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp)
	begin
		$display("ERR %s expected %h actual %h", name, exp, act);
		$display("TEST FAILED");
		$fatal(1);
	end
endtask

task automatic idle_cycles(input int n);
	repeat (n) @(negedge clk_apb);
endtask

// **************************************************
// APB master
// **************************************************
task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
	output logic [31:0] rdata, output logic err);
	@(negedge clk_apb);
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite  = wr;
	apb_req.paddr   = addr;
	apb_req.pwdata  = wdata;
	@(negedge clk_apb);
	apb_req.penable = 1'b1;
	#1;
	// No wait states, so pready is due in the first access cycle
	check_value("apb pready", 32'h1, {31'h0, apb_rsp.pready});
	rdata = apb_rsp.prdata;
	err   = apb_rsp.pslverr;
	@(negedge clk_apb);
	apb_req.psel    = 1'b0;
	apb_req.penable = 1'b0;
endtask

task automatic reg_write(input logic [7:0] off, input logic [31:0] data);
	logic [31:0] rdata;
	logic        err;
	apb_access(1'b1, {24'h0, off}, data, rdata, err);
	check_value($sformatf("apb write %h pslverr", off), 32'h0, {31'h0, err});
endtask

task automatic reg_read(input logic [7:0] off, output logic [31:0] data);
	logic err;
	apb_access(1'b0, {24'h0, off}, 32'h0, data, err);
	check_value($sformatf("apb read %h pslverr", off), 32'h0, {31'h0, err});
endtask

task automatic write_readback(input string name, input logic [7:0] off, input logic [31:0] val);
	logic [31:0] rdata;
	reg_write(off, val);
	reg_read(off, rdata);
	check_value(name, val, rdata);
endtask

task automatic clear_irq(input string name);
	logic [31:0] rdata;
	reg_write(`DMA_REG_STATUS, 32'h2);
	reg_read(`DMA_REG_STATUS, rdata);
	check_value({name, " status after irq clear"}, 32'h0, rdata);
	check_value({name, " o_irq after irq clear"}, 32'h0, {31'h0, irq});
endtask

task automatic wait_status(input int idx, input logic val, input string what);
	logic [31:0] st;
	int          n;
	n = 0;
	reg_read(`DMA_REG_STATUS, st);
	while (st[idx] !== val)
	begin
		if (n == TIMEOUT)
			abort_run(what);
		reg_read(`DMA_REG_STATUS, st);
		n++;
	end
endtask

task automatic wait_runs(input logic [31:0] target, input string name);
	logic [31:0] runs;
	int          n;
	n = 0;
	reg_read(`DMA_REG_RUNS, runs);
	while (runs < target)
	begin
		if (n == TIMEOUT)
			abort_run({name, " run count stopped rising in repeat mode"});
		reg_read(`DMA_REG_RUNS, runs);
		n++;
	end
endtask

// **************************************************
// Source and destination memory models
// **************************************************
initial
begin : bus_model
	logic [1:0] lat;
	mem_rsp_t   rsp;
	forever
	begin
		@(negedge clk_apb);
		cyc++;
		// In-order read returns, one per cycle
		rsp = '0;
		if ((rd_addr_q.size() > 0) && (rd_due_q[0] <= cyc))
		begin
			rsp.valid = 1'b1;
			rsp.data  = src_mem[rd_addr_q.pop_front()];
			void'(rd_due_q.pop_front());
		end
		rd_rsp   = rsp;
		rd_ready = full_ready ? 1'b1 : lfsr_bit();
		wr_ready = full_ready ? 1'b1 : lfsr_bit();
		tick_1us = tick_en ? lfsr_bit() : 1'b0;
		#1;
		if (rd_req.valid && (rd_req.addr > 32'd255))
			abort_run("read address lies outside the source memory");
		if (wr_req.valid && (wr_req.addr > 32'd255))
			abort_run("write address lies outside the destination memory");
		if (rd_req.valid && rd_ready)
		begin
			lat[0] = lfsr_bit();
			lat[1] = lfsr_bit();
			rd_addr_q.push_back(rd_req.addr[7:0]);
			rd_due_q.push_back(cyc + 1 + int'(lat));
			rd_count++;
		end
		if (wr_req.valid && wr_ready)
		begin
			dst_mem[wr_req.addr[7:0]] = wr_req.data;
			wr_count++;
		end
	end
end

// **************************************************
// One table row
// **************************************************
task automatic run_row(input int idx);
	row_t        t;
	string       name;
	logic [31:0] rdata;
	logic [31:0] runs0;
	logic [31:0] runs1;
	int          i;
	int          l;
	int          w;
	t    = tests[idx];
	name = names[idx];
	for (i = 0; i < 256; i++)
		dst_mem[i] = {8'hD0, 8'(i), ~8'(i), 8'h3C};
	exp_mem = dst_mem;
	for (l = 0; l < int'(t.lines); l++)
		for (w = 0; w < int'(t.words); w++)
			exp_mem[(int'(t.dst) + l * int'(t.dst_stride) + w) & 255] =
				src_mem[(int'(t.src) + l * int'(t.src_stride) + w) & 255];

	reg_write(`DMA_REG_SRC, t.src);
	reg_write(`DMA_REG_DST, t.dst);
	reg_write(`DMA_REG_SIZE, {t.lines, t.words});
	reg_write(`DMA_REG_STRIDE, {t.dst_stride, t.src_stride});
	reg_write(`DMA_REG_PERIOD, {24'h0, t.period});
	clear_irq(name);
	reg_read(`DMA_REG_RUNS, runs0);
	rd_count   = 0;
	wr_count   = 0;
	full_ready = t.full_ready;
	tick_en    = t.rpt;
	reg_write(`DMA_REG_CTRL, {30'h0, t.rpt, 1'b1});
	// Second start lands while the first transfer is still busy
	if (t.poke)
		reg_write(`DMA_REG_CTRL, 32'h1);

	if (t.rpt)
	begin
		wait_runs(runs0 + 32'd3, name);
		reg_write(`DMA_REG_CTRL, 32'h0);
		wait_status(0, 1'b0, {name, " stayed busy after repeat was cleared"});
		reg_read(`DMA_REG_RUNS, runs1);
		idle_cycles(40);
		reg_read(`DMA_REG_RUNS, rdata);
		check_value({name, " runs after repeat cleared"}, runs1, rdata);
	end
	else
	begin
		wait_status(1, 1'b1, {name, " never raised the completion interrupt"});
		reg_read(`DMA_REG_STATUS, rdata);
		check_value({name, " status at completion"}, 32'h2, rdata);
		check_value({name, " o_irq at completion"}, 32'h1, {31'h0, irq});
		reg_read(`DMA_REG_RUNS, runs1);
		check_value({name, " run count"}, runs0 + 32'd1, runs1);
		idle_cycles(10);
		reg_read(`DMA_REG_STATUS, rdata);
		check_value({name, " busy after idle"}, 32'h0, {31'h0, rdata[0]});
	end
	tick_en = 1'b0;

	for (i = 0; i < 256; i++)
		check_value($sformatf("%s dst[%0d]", name, i), exp_mem[i], dst_mem[i]);
	check_value({name, " write count"},
		(runs1 - runs0) * 32'(t.lines) * 32'(t.words), 32'(wr_count));
	check_value({name, " read count"},
		(runs1 - runs0) * 32'(t.lines) * 32'(t.words), 32'(rd_count));
	clear_irq(name);
endtask

// **************************************************
// Main sequence
// **************************************************
initial
begin : main
	logic [31:0] rdata;
	logic        err;
	int          i;
	apb_req    = '0;
	rd_rsp     = '0;
	rd_ready   = 1'b0;
	wr_ready   = 1'b0;
	tick_1us   = 1'b0;
	full_ready = 1'b0;
	tick_en    = 1'b0;
	rd_count   = 0;
	wr_count   = 0;
	cyc        = 0;
	lfsr       = 32'h50b3;
	rstnn_apb  = 1'b0;
	for (i = 0; i < 256; i++)
		src_mem[i] = {8'hA5, 8'(i), 8'(i * 7), ~8'(i)};

	// src, dst, words, lines, src stride, dst stride, full ready, repeat, poke, period
	names[0] = "single_line";
	tests[0] = '{32'h10, 32'h80, 16'd8, 16'd1, 16'd0, 16'd0, 1'b1, 1'b0, 1'b0, 8'd0};
	names[1] = "lines_strided";
	tests[1] = '{32'h00, 32'hA0, 16'd3, 16'd4, 16'd10, 16'd5, 1'b0, 1'b0, 1'b0, 8'd0};
	names[2] = "busy_restart";
	tests[2] = '{32'h40, 32'h90, 16'd6, 16'd3, 16'd8, 16'd7, 1'b0, 1'b0, 1'b1, 8'd0};
	names[3] = "zero_lines";
	tests[3] = '{32'h30, 32'h60, 16'd4, 16'd0, 16'd1, 16'd1, 1'b0, 1'b0, 1'b0, 8'd0};
	names[4] = "repeat_runs";
	tests[4] = '{32'h20, 32'hC0, 16'd2, 16'd1, 16'd0, 16'd0, 1'b0, 1'b1, 1'b0, 8'd2};

	repeat (5) @(negedge clk_apb);
	rstnn_apb = 1'b1;
	check_value("reset read valid", 32'h0, {31'h0, rd_req.valid});
	check_value("reset write valid", 32'h0, {31'h0, wr_req.valid});
	check_value("reset o_irq", 32'h0, {31'h0, irq});
	reg_read(`DMA_REG_STATUS, rdata);
	check_value("reset status", 32'h0, rdata);
	reg_read(`DMA_REG_RUNS, rdata);
	check_value("reset runs", 32'h0, rdata);

	// Register readback and unmapped accesses
	write_readback("regs src", `DMA_REG_SRC, 32'h1234_5678);
	write_readback("regs dst", `DMA_REG_DST, 32'h9ABC_DEF0);
	write_readback("regs size", `DMA_REG_SIZE, 32'h0003_0005);
	write_readback("regs stride", `DMA_REG_STRIDE, 32'h000A_0007);
	write_readback("regs period", `DMA_REG_PERIOD, 32'h0000_0011);
	write_readback("regs ctrl repeat", `DMA_REG_CTRL, 32'h2);
	write_readback("regs ctrl clear", `DMA_REG_CTRL, 32'h0);
	apb_access(1'b0, 32'h20, 32'h0, rdata, err);
	check_value("regs unmapped read pslverr", 32'h1, {31'h0, err});
	apb_access(1'b1, 32'h104, 32'hFFFF_FFFF, rdata, err);
	check_value("regs high address pslverr", 32'h1, {31'h0, err});
	reg_read(`DMA_REG_SRC, rdata);
	check_value("regs unmapped write ignored", 32'h1234_5678, rdata);

	for (i = 0; i < NUM_TESTS; i++)
		run_row(i);

	$display("TEST PASSED");
	$finish;
end

endmodule
